// ==== hdl/pwm_config_pkg.sv ====
package pwm_config_pkg;

    // Width of the shared counter and of every threshold compared against it
    localparam int COUNTER_WIDTH = 16;

    // Bit positions inside the two-bit output enable field
    localparam int OUTPUT_A = 0;
    localparam int OUTPUT_B = 1;

    typedef enum logic [2:0] {
        mode_up      = 3'd0,
        mode_down    = 3'd1,
        mode_up_down = 3'd2
    } counter_mode_e;

    // Settings shared by the whole chain
    typedef struct packed {
        counter_mode_e            mode;
        logic [COUNTER_WIDTH-1:0] start_value;
        logic [COUNTER_WIDTH-1:0] stop_value;
        logic [15:0]              timebase_shift;
    } chain_config_t;

    // Settings of one output channel
    typedef struct packed {
        logic [COUNTER_WIDTH-1:0] threshold_high;
        logic [COUNTER_WIDTH-1:0] threshold_low;
        logic [1:0]               output_enable;
        logic [COUNTER_WIDTH-1:0] deadtime;
        logic                     deadtime_enable;
    } channel_config_t;

endpackage

// ==== hdl/pwm_regs_pkg.sv ====
package pwm_regs_pkg;

    // Chain registers sit below the first channel block
    typedef enum logic [7:0] {
        addr_mode         = 8'd0,
        addr_start        = 8'd1,
        addr_stop         = 8'd2,
        addr_shift        = 8'd3,
        addr_channel_base = 8'd4
    } reg_addr_e;

    localparam logic [7:0] CHANNEL_STRIDE = 8'd4;

    // Register offsets inside one channel block
    typedef enum logic [1:0] {
        offset_threshold_high = 2'd0,
        offset_threshold_low  = 2'd1,
        offset_output_enable  = 2'd2,
        offset_deadtime       = 2'd3
    } channel_offset_e;

    localparam int DEADTIME_ENABLE_BIT = 16;

    typedef struct packed {
        logic        write;
        logic [7:0]  addr;
        logic [31:0] data;
    } reg_write_t;

endpackage

// ==== hdl/chain_control_unit.sv ====
`timescale 1ns/100ps

module chain_control_unit #(
    parameter int N_CHANNELS = 4
) (
    input  logic                            clock,
    input  logic                            reset,
    input  pwm_regs_pkg::reg_write_t        reg_write,
    output pwm_config_pkg::chain_config_t   chain_config,
    output pwm_config_pkg::channel_config_t channel_config [N_CHANNELS]
);
    import pwm_config_pkg::*;
    import pwm_regs_pkg::*;

    logic [7:0]      channel_addr;
    logic [7:0]      channel_index;
    channel_offset_e channel_offset;
    logic            channel_hit;

    // Split a channel address into the channel number and the register inside it
    assign channel_addr   = reg_write.addr - addr_channel_base;
    assign channel_index  = channel_addr / CHANNEL_STRIDE;
    assign channel_offset = channel_offset_e'(2'(channel_addr % CHANNEL_STRIDE));
    assign channel_hit    = (reg_write.addr >= addr_channel_base)
                         && (32'(channel_index) < N_CHANNELS);

    always_ff @(posedge clock) begin
        if (!reset) begin
            chain_config <= '0;
            for (int i = 0; i < N_CHANNELS; i++) begin
                channel_config[i] <= '0;
            end
        end else if (reg_write.write) begin
            case (reg_write.addr)
                addr_mode:  chain_config.mode <= counter_mode_e'(reg_write.data[2:0]);
                addr_start: chain_config.start_value <= reg_write.data[COUNTER_WIDTH-1:0];
                addr_stop:  chain_config.stop_value <= reg_write.data[COUNTER_WIDTH-1:0];
                addr_shift: chain_config.timebase_shift <= reg_write.data[15:0];
                default: begin
                    // Anything above the chain registers belongs to a channel, if one exists
                    for (int i = 0; i < N_CHANNELS; i++) begin
                        if (channel_hit && (32'(channel_index) == i)) begin
                            case (channel_offset)
                                offset_threshold_high: channel_config[i].threshold_high <=
                                    reg_write.data[COUNTER_WIDTH-1:0];
                                offset_threshold_low: channel_config[i].threshold_low <=
                                    reg_write.data[COUNTER_WIDTH-1:0];
                                offset_output_enable: channel_config[i].output_enable <=
                                    reg_write.data[1:0];
                                offset_deadtime: begin
                                    channel_config[i].deadtime <=
                                        reg_write.data[COUNTER_WIDTH-1:0];
                                    channel_config[i].deadtime_enable <=
                                        reg_write.data[DEADTIME_ENABLE_BIT];
                                end
                                default: ;
                            endcase
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== hdl/enable_delay.sv ====
`timescale 1ns/100ps

module enable_delay (
    input  logic        clock,
    input  logic        reset,
    input  logic        enable,
    input  logic [15:0] delay,
    output logic        delayed_enable
);
    logic [15:0] wait_count;
    logic [16:0] next_count;

    assign next_count = {1'b0, wait_count} + 17'd1;

    // The wait restarts from zero whenever the request drops
    always_ff @(posedge clock) begin
        if (!reset) begin
            wait_count     <= '0;
            delayed_enable <= 1'b0;
        end else if (!enable) begin
            wait_count     <= '0;
            delayed_enable <= 1'b0;
        end else if (!delayed_enable) begin
            if (next_count >= {1'b0, delay}) begin
                delayed_enable <= 1'b1;
            end else begin
                wait_count <= next_count[15:0];
            end
        end
    end

endmodule

// ==== hdl/pwm_counter.sv ====
`timescale 1ns/100ps

module pwm_counter (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   sync,
    input  logic                                   timebase,
    input  logic                                   run,
    input  pwm_config_pkg::chain_config_t          chain_config,
    output logic [pwm_config_pkg::COUNTER_WIDTH-1:0] count,
    output logic                                   reload
);
    import pwm_config_pkg::*;

    typedef enum logic {
        count_up,
        count_down
    } direction_e;

    direction_e direction;
    logic       at_start;
    logic       at_stop;
    logic       turn;
    logic       in_range;

    assign at_start = count <= chain_config.start_value;
    assign at_stop  = count >= chain_config.stop_value;
    assign turn     = chain_config.mode == mode_up_down;
    assign in_range = (count >= chain_config.start_value) && (count <= chain_config.stop_value);

    // A new period begins each time the count leaves start_value
    assign reload = run && timebase && (count == chain_config.start_value);

    always_ff @(posedge clock) begin
        if (!reset) begin
            count     <= '0;
            direction <= count_up;
        end else if (sync || !run) begin
            count     <= chain_config.start_value;
            direction <= (chain_config.mode == mode_down) ? count_down : count_up;
        end else if (timebase) begin
            case (direction)
                count_up: begin
                    if (!at_stop) begin
                        count <= count + 1'b1;
                    end else if (turn) begin
                        count     <= count - 1'b1;
                        direction <= count_down;
                    end else begin
                        count <= chain_config.start_value;
                    end
                end
                default: begin
                    if (!at_start) begin
                        count <= count - 1'b1;
                    end else if (turn) begin
                        count     <= count + 1'b1;
                        direction <= count_up;
                    end else begin
                        count <= chain_config.stop_value;
                    end
                end
            endcase
        end
    end

    // Once inside the programmed window the count stays there until the window moves
    count_in_window: assert property (@(posedge clock) disable iff (!reset)
        (run && in_range) |=> (!$stable(chain_config) || in_range));

endmodule

// ==== hdl/compare_unit.sv ====
`timescale 1ns/100ps

module compare_unit #(
    parameter int N_CHANNELS = 4
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     counter_stopped,
    input  logic [pwm_config_pkg::COUNTER_WIDTH-1:0] count,
    input  logic                                     reload,
    input  pwm_config_pkg::channel_config_t          channel_config [N_CHANNELS],
    output logic [N_CHANNELS-1:0]                    match_high,
    output logic [N_CHANNELS-1:0]                    match_low
);
    import pwm_config_pkg::*;

    logic [COUNTER_WIDTH-1:0] shadow_high [N_CHANNELS];
    logic [COUNTER_WIDTH-1:0] shadow_low  [N_CHANNELS];
    logic [COUNTER_WIDTH-1:0] active_high [N_CHANNELS];
    logic [COUNTER_WIDTH-1:0] active_low  [N_CHANNELS];
    logic                     load;

    assign load = reload || counter_stopped;

    // New thresholds already apply to the first count of the period they load in
    always_comb begin
        for (int i = 0; i < N_CHANNELS; i++) begin
            active_high[i] = load ? channel_config[i].threshold_high : shadow_high[i];
            active_low[i]  = load ? channel_config[i].threshold_low : shadow_low[i];
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            for (int i = 0; i < N_CHANNELS; i++) begin
                shadow_high[i] <= channel_config[i].threshold_high;
                shadow_low[i]  <= channel_config[i].threshold_low;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            match_high <= '0;
            match_low  <= '0;
        end else begin
            for (int i = 0; i < N_CHANNELS; i++) begin
                match_high[i] <= count == active_high[i];
                match_low[i]  <= count == active_low[i];
            end
        end
    end

endmodule

// ==== hdl/pin_control.sv ====
`timescale 1ns/100ps

module pin_control (
    input  logic       clock,
    input  logic       reset,
    input  logic       match_high,
    input  logic       match_low,
    input  logic [1:0] output_enable,
    input  logic       counter_stopped,
    output logic       raw_a,
    output logic       raw_b
);
    import pwm_config_pkg::*;

    logic state;

    // A clear wins over a set that lands in the same cycle
    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= 1'b0;
        end else if (counter_stopped || match_low) begin
            state <= 1'b0;
        end else if (match_high) begin
            state <= 1'b1;
        end
    end

    assign raw_a = state && output_enable[OUTPUT_A] && !counter_stopped;
    assign raw_b = !state && output_enable[OUTPUT_B] && !counter_stopped;

endmodule

// ==== hdl/deadtime_generator.sv ====
`timescale 1ns/100ps

module deadtime_generator (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     enable,
    input  logic [pwm_config_pkg::COUNTER_WIDTH-1:0] deadtime,
    input  logic                                     in_a,
    input  logic                                     in_b,
    output logic                                     out_a,
    output logic                                     out_b
);
    import pwm_config_pkg::*;

    logic [1:0] side_in;
    logic [1:0] side_out;

    assign side_in[OUTPUT_A] = in_a;
    assign side_in[OUTPUT_B] = in_b;
    assign out_a = side_out[OUTPUT_A];
    assign out_b = side_out[OUTPUT_B];

    // Both sides behave the same, each with its own wait counter
    for (genvar s = 0; s < 2; s++) begin : gen_side
        logic [COUNTER_WIDTH-1:0] wait_count;

        always_ff @(posedge clock) begin
            if (!reset) begin
                side_out[s] <= 1'b0;
                wait_count  <= '0;
            end else if (!side_in[s]) begin
                // Turn-off is never delayed
                side_out[s] <= 1'b0;
                wait_count  <= '0;
            end else if (!enable || (wait_count >= deadtime)) begin
                side_out[s] <= 1'b1;
            end else begin
                wait_count <= wait_count + 1'b1;
            end
        end
    end

    out_pair_exclusive: assert property (@(posedge clock) disable iff (!reset)
        !(out_a && out_b));

endmodule

// ==== hdl/pwm_chain.sv ====
`timescale 1ns/100ps

module pwm_chain #(
    parameter int N_CHANNELS = 4
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     timebase,
    input  logic                     external_counter_run,
    input  logic                     sync,
    input  logic                     stop_request,
    input  pwm_regs_pkg::reg_write_t reg_write,
    output logic                     counter_status,
    output logic [N_CHANNELS-1:0]    out_a,
    output logic [N_CHANNELS-1:0]    out_b
);
    import pwm_config_pkg::*;

    chain_config_t            chain_config;
    channel_config_t          channel_config [N_CHANNELS];
    logic                     run_request;
    logic                     counter_enable;
    logic                     counter_stopped;
    logic [COUNTER_WIDTH-1:0] count;
    logic                     reload;
    logic [N_CHANNELS-1:0]    match_high;
    logic [N_CHANNELS-1:0]    match_low;
    logic [N_CHANNELS-1:0]    raw_a;
    logic [N_CHANNELS-1:0]    raw_b;

    assign run_request    = external_counter_run && !stop_request;
    assign counter_status = !counter_stopped;

    always_ff @(posedge clock) begin
        if (!reset) begin
            counter_stopped <= 1'b1;
        end else begin
            counter_stopped <= !counter_enable;
        end
    end

    chain_control_unit #(
        .N_CHANNELS(N_CHANNELS)
    ) control_i (
        .clock(clock),
        .reset(reset),
        .reg_write(reg_write),
        .chain_config(chain_config),
        .channel_config(channel_config)
    );

    enable_delay shift_i (
        .clock(clock),
        .reset(reset),
        .enable(run_request),
        .delay(chain_config.timebase_shift),
        .delayed_enable(counter_enable)
    );

    pwm_counter counter_i (
        .clock(clock),
        .reset(reset),
        .sync(sync),
        .timebase(timebase),
        .run(counter_enable),
        .chain_config(chain_config),
        .count(count),
        .reload(reload)
    );

    compare_unit #(
        .N_CHANNELS(N_CHANNELS)
    ) compare_i (
        .clock(clock),
        .reset(reset),
        .counter_stopped(counter_stopped),
        .count(count),
        .reload(reload),
        .channel_config(channel_config),
        .match_high(match_high),
        .match_low(match_low)
    );

    for (genvar i = 0; i < N_CHANNELS; i++) begin : gen_channel
        pin_control pin_i (
            .clock(clock),
            .reset(reset),
            .match_high(match_high[i]),
            .match_low(match_low[i]),
            .output_enable(channel_config[i].output_enable),
            .counter_stopped(counter_stopped),
            .raw_a(raw_a[i]),
            .raw_b(raw_b[i])
        );

        deadtime_generator deadtime_i (
            .clock(clock),
            .reset(reset),
            .enable(channel_config[i].deadtime_enable),
            .deadtime(channel_config[i].deadtime),
            .in_a(raw_a[i]),
            .in_b(raw_b[i]),
            .out_a(out_a[i]),
            .out_b(out_b[i])
        );
    end

endmodule

// ==== test/pwm_chain_tb.sv ====
`timescale 1ns/100ps

module pwm_chain_tb;
    import pwm_config_pkg::*;
    import pwm_regs_pkg::*;

    localparam int N_CHANNELS = 4;
    // The directed tests need roughly a thousand cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int SAW_PERIOD = 10;
    localparam int TRIANGLE_PERIOD = 16;
    localparam int DEADTIME = 3;
    localparam int SHIFT = 5;

    logic                  clock;
    logic                  reset;
    logic                  timebase;
    logic                  external_counter_run;
    logic                  sync;
    logic                  stop_request;
    reg_write_t            reg_write;
    logic                  counter_status;
    logic [N_CHANNELS-1:0] out_a;
    logic [N_CHANNELS-1:0] out_b;

    int cycle_count;
    int check_count;
    int error_count;
    int saw_high;
    int saw_low;

    pwm_chain #(
        .N_CHANNELS(N_CHANNELS)
    ) dut_i (
        .clock(clock),
        .reset(reset),
        .timebase(timebase),
        .external_counter_run(external_counter_run),
        .sync(sync),
        .stop_request(stop_request),
        .reg_write(reg_write),
        .counter_status(counter_status),
        .out_a(out_a),
        .out_b(out_b)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input int got, input int expected);
        check_count++;
        assert (got == expected) else begin
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_true(input string what, input logic condition);
        check_count++;
        assert (condition) else begin
            $display("ERROR t=%0t: %s", $time, what);
            error_count++;
        end
    endtask

    function automatic logic [7:0] channel_reg(input int channel, input int offset);
        return 8'(int'(addr_channel_base) + channel * int'(CHANNEL_STRIDE) + offset);
    endfunction

    // One write strobe, held for a single rising edge
    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clock);
        reg_write <= '{write: 1'b1, addr: addr, data: data};
        @(posedge clock);
        reg_write <= '0;
    endtask

    task automatic set_run(input logic value);
        @(posedge clock);
        external_counter_run <= value;
    endtask

    task automatic configure_chain(input counter_mode_e mode, input int start, input int stop,
            input int shift);
        write_reg(addr_mode, 32'(mode));
        write_reg(addr_start, 32'(start));
        write_reg(addr_stop, 32'(stop));
        write_reg(addr_shift, 32'(shift));
    endtask

    task automatic configure_channel0(input int high, input int low, input int enables,
            input int deadtime_word);
        write_reg(channel_reg(0, int'(offset_threshold_high)), 32'(high));
        write_reg(channel_reg(0, int'(offset_threshold_low)), 32'(low));
        write_reg(channel_reg(0, int'(offset_output_enable)), 32'(enables));
        write_reg(channel_reg(0, int'(offset_deadtime)), 32'(deadtime_word));
    endtask

    // Samples channel 0 on falling edges, where the outputs are stable
    task automatic measure_channel0(input int cycles, output int high_a, output int high_b,
            output int rises_a, output int both_high, output int min_gap);
        logic prev_a;
        logic seen_high;
        int   low_run;
        high_a    = 0;
        high_b    = 0;
        rises_a   = 0;
        both_high = 0;
        min_gap   = cycles;
        low_run   = 0;
        @(negedge clock);
        prev_a    = out_a[0];
        seen_high = out_a[0] || out_b[0];
        repeat (cycles) begin
            @(negedge clock);
            if (out_a[0]) high_a++;
            if (out_b[0]) high_b++;
            if (out_a[0] && !prev_a) rises_a++;
            if (out_a[0] && out_b[0]) both_high++;
            if (!out_a[0] && !out_b[0]) begin
                low_run++;
            end else begin
                // Only gaps between two high intervals count, not the partial first one
                if (seen_high && (low_run > 0) && (low_run < min_gap)) min_gap = low_run;
                seen_high = 1'b1;
                low_run   = 0;
            end
            prev_a = out_a[0];
        end
    endtask

    task automatic test_reset_state();
        repeat (50) begin
            @(negedge clock);
            check_value("out_a", int'(out_a), 0);
            check_value("out_b", int'(out_b), 0);
            check_value("counter_status", int'(counter_status), 0);
        end
    endtask

    task automatic test_sawtooth_duty();
        int high_a;
        int high_b;
        int rises_a;
        int both_high;
        int min_gap;
        saw_high = $urandom % 8;
        saw_low  = saw_high + 1 + ($urandom % (9 - saw_high));
        $display("Sawtooth thresholds: high %0d, low %0d", saw_high, saw_low);
        configure_chain(mode_up, 0, 9, 0);
        configure_channel0(saw_high, saw_low, 3, 0);
        set_run(1'b1);
        repeat (30) @(posedge clock);
        measure_channel0(5 * SAW_PERIOD, high_a, high_b, rises_a, both_high, min_gap);
        check_value("out_a[0] high cycles", high_a, 5 * (saw_low - saw_high));
        check_value("out_b[0] high cycles", high_b, 5 * (SAW_PERIOD - (saw_low - saw_high)));
        check_value("out_a[0] rising edges", rises_a, 5);
        check_value("out_a[0] and out_b[0] overlap", both_high, 0);
    endtask

    task automatic test_output_enable();
        int high_a;
        int high_b;
        int rises_a;
        int both_high;
        int min_gap;
        write_reg(channel_reg(0, int'(offset_output_enable)), 32'd1);
        repeat (20) @(posedge clock);
        measure_channel0(5 * SAW_PERIOD, high_a, high_b, rises_a, both_high, min_gap);
        check_value("out_a[0] high cycles, A only", high_a, 5 * (saw_low - saw_high));
        check_value("out_b[0] high cycles, A only", high_b, 0);
        write_reg(channel_reg(0, int'(offset_output_enable)), 32'd0);
        repeat (20) @(posedge clock);
        measure_channel0(5 * SAW_PERIOD, high_a, high_b, rises_a, both_high, min_gap);
        check_value("out_a[0] high cycles, disabled", high_a, 0);
        check_value("out_b[0] high cycles, disabled", high_b, 0);
        set_run(1'b0);
    endtask

    task automatic test_deadtime();
        int high_a;
        int high_b;
        int rises_a;
        int both_high;
        int min_gap;
        configure_channel0(2, 8, 3, (1 << DEADTIME_ENABLE_BIT) | DEADTIME);
        set_run(1'b1);
        repeat (30) @(posedge clock);
        measure_channel0(5 * SAW_PERIOD, high_a, high_b, rises_a, both_high, min_gap);
        // Each turn-on edge loses the dead time, turn-off edges stay where they were
        check_value("out_a[0] high cycles with dead time", high_a, 5 * (6 - DEADTIME));
        check_value("out_b[0] high cycles with dead time", high_b,
            5 * (SAW_PERIOD - 6 - DEADTIME));
        check_value("out_a[0] and out_b[0] overlap", both_high, 0);
        check_true("gap between out_a[0] and out_b[0] is shorter than the dead time",
            min_gap >= DEADTIME);
        set_run(1'b0);
        write_reg(channel_reg(0, int'(offset_deadtime)), 32'd0);
    endtask

    task automatic test_triangle();
        int high_a;
        int high_b;
        int rises_a;
        int both_high;
        int min_gap;
        configure_chain(mode_up_down, 0, 8, 0);
        configure_channel0(3, 6, 3, 0);
        set_run(1'b1);
        repeat (40) @(posedge clock);
        measure_channel0(4 * TRIANGLE_PERIOD, high_a, high_b, rises_a, both_high, min_gap);
        // Set at 3 on the down slope, cleared at 6 on the next up slope, so 3 + 6 cycles high
        check_value("out_a[0] high cycles, triangle", high_a, 4 * (3 + 6));
        check_value("out_b[0] high cycles, triangle", high_b, 4 * (TRIANGLE_PERIOD - 9));
        check_value("out_a[0] rising edges, triangle", rises_a, 4);
        set_run(1'b0);
    endtask

    task automatic test_shift_and_stop();
        int high_a;
        int high_b;
        int rises_a;
        int both_high;
        int min_gap;
        int latency;
        configure_chain(mode_up, 0, 9, SHIFT);
        configure_channel0(2, 7, 3, 0);
        repeat (5) @(posedge clock);
        set_run(1'b1);
        latency = 0;
        do begin
            @(negedge clock);
            latency++;
        end while (!counter_status && (latency < 100));
        check_true("counter_status did not rise within 100 cycles of run", counter_status);
        check_true("counter_status rose before the phase shift elapsed", latency >= SHIFT);
        repeat (30) @(posedge clock);
        measure_channel0(5 * SAW_PERIOD, high_a, high_b, rises_a, both_high, min_gap);
        check_value("out_a[0] rising edges while shifted", rises_a, 5);
        @(posedge clock);
        stop_request <= 1'b1;
        latency = 0;
        do begin
            @(negedge clock);
            latency++;
        end while (counter_status && (latency < 100));
        check_true("counter_status did not fall after stop_request", !counter_status);
        repeat (3) @(posedge clock);
        repeat (20) begin
            @(negedge clock);
            check_value("out_a after stop", int'(out_a), 0);
            check_value("out_b after stop", int'(out_b), 0);
        end
        @(posedge clock);
        stop_request         <= 1'b0;
        external_counter_run <= 1'b0;
        write_reg(addr_shift, 32'd0);
    endtask

    initial begin
        clock                = 1'b0;
        reset                = 1'b0;
        timebase             = 1'b1;
        external_counter_run = 1'b0;
        sync                 = 1'b0;
        stop_request         = 1'b0;
        reg_write            = '0;
        cycle_count          = 0;
        check_count          = 0;
        error_count          = 0;
        void'($urandom(31));
        repeat (10) @(posedge clock);
        reset <= 1'b1;
        test_reset_state();
        test_sawtooth_duty();
        test_output_enable();
        test_deadtime();
        test_triangle();
        test_shift_and_stop();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/pwm_config_pkg.sv
hdl/pwm_regs_pkg.sv
hdl/chain_control_unit.sv
hdl/enable_delay.sv
hdl/pwm_counter.sv
hdl/compare_unit.sv
hdl/pin_control.sv
hdl/deadtime_generator.sv
hdl/pwm_chain.sv
test/pwm_chain_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := pwm_chain_tb
RTL_TOP    := pwm_chain
FILE_LIST  := compile.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
